// ==== rtl/app_controller.sv ====
// App controller for the touch console
// Runs the app FSM with its nested breakout FSM, drives the game controls,
// follows the paddle target and latches the last keypad key
// Expects registered tap/press and hit flags from the touch front end

`default_nettype none

module app_controller (
    input  wire                            clk_50,
    input  wire                            reset_n,
    input  wire                            tap,
    input  wire                            press,
    input  wire                            ball_lost,
    input  wire touch_ui_pkg::game_x_t     game_x,
    input  wire                            hit_gif_icon,
    input  wire                            hit_kp_icon,
    input  wire                            hit_brk_icon,
    input  wire                            hit_home_btn,
    input  wire                            hit_play,
    input  wire                            hit_exit,
    input  wire                            key_hit,
    input  wire touch_ui_pkg::hex_digit_t  key_value,
    output touch_ui_pkg::app_state_t       app_state,
    output touch_ui_pkg::brk_state_t       brk_state,
    output logic                           game_run,
    output logic                           new_game,
    output logic [8:0]                     paddle_target_x,
    output touch_ui_pkg::hex_digit_t       selected_hex
);

    import touch_ui_pkg::*;

    logic in_play;

    assign in_play = (app_state == BREAKOUT) && (brk_state == B_PLAY);

    // ----------------------------------------------------------------------
    // App and breakout FSMs
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_50 or negedge reset_n) begin
        if (!reset_n) begin
            app_state <= HOME;
            brk_state <= B_IDLE;
            game_run  <= 1'b0;
            new_game  <= 1'b0;
        end else begin
            // One-cycle pulse
            new_game <= 1'b0;
            case (app_state)
                HOME: begin
                    // Breakout wins over the other icons
                    if (tap && hit_brk_icon) begin
                        app_state <= BREAKOUT;
                        brk_state <= B_PLAY;
                        game_run  <= 1'b1;
                        new_game  <= 1'b1;
                    end else if (tap && hit_gif_icon) begin
                        app_state <= GIF;
                    end else if (tap && hit_kp_icon) begin
                        app_state <= KEYPAD;
                    end
                end
                BREAKOUT: begin
                    case (brk_state)
                        B_PLAY: begin
                            if (ball_lost) begin
                                brk_state <= B_GAME_OVER;
                                game_run  <= 1'b0;
                            end
                        end
                        B_GAME_OVER: begin
                            if (tap && hit_play) begin
                                brk_state <= B_PLAY;
                                game_run  <= 1'b1;
                                new_game  <= 1'b1;
                            end else if (tap && hit_exit) begin
                                app_state <= HOME;
                                brk_state <= B_IDLE;
                            end
                        end
                        // Idle inside breakout is not a real screen, fall back home
                        default: begin
                            app_state <= HOME;
                            brk_state <= B_IDLE;
                            game_run  <= 1'b0;
                        end
                    endcase
                end
                // GIF and keypad apps share the home button
                default: begin
                    if (tap && hit_home_btn) begin
                        app_state <= HOME;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Paddle target follows the finger during play
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_50 or negedge reset_n) begin
        if (!reset_n) begin
            paddle_target_x <= PADDLE_RESET_X;
        end else if (in_play && press) begin
            paddle_target_x <= game_x[8:0];
        end
    end

    // Keypad value latch
    always_ff @(posedge clk_50 or negedge reset_n) begin
        if (!reset_n) begin
            selected_hex <= '0;
        end else if ((app_state == KEYPAD) && tap && key_hit) begin
            selected_hex <= key_value;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hit_decoder.sv ====
// Hitbox tests for the mapped touch point
// Flags every icon, button and keypad key that contains the point
// Purely combinational, the app controller picks which flags matter

`default_nettype none

module hit_decoder (
    input  wire touch_ui_pkg::game_x_t game_x,
    input  wire touch_ui_pkg::game_y_t game_y,
    output logic                       hit_gif_icon,
    output logic                       hit_kp_icon,
    output logic                       hit_brk_icon,
    output logic                       hit_home_btn,
    output logic                       hit_play,
    output logic                       hit_exit,
    output logic                       key_hit,
    output touch_ui_pkg::hex_digit_t   key_value
);

    import touch_ui_pkg::*;

    logic [1:0] key_col;
    logic [1:0] key_row;

    // Point inside [x0,x1) x [y0,y1)
    function automatic logic in_box(
        input game_x_t px,
        input game_y_t py,
        input game_x_t x0,
        input game_x_t x1,
        input game_y_t y0,
        input game_y_t y1
    );
        return (px >= x0) && (px < x1) && (py >= y0) && (py < y1);
    endfunction

    // ----------------------------------------------------------------------
    // Home screen icons, widened by the hit margin on every side
    // ----------------------------------------------------------------------
    assign hit_gif_icon = in_box(game_x, game_y,
        game_x_t'(GIF_ICON_X0 - ICON_HIT_MARGIN),
        game_x_t'(GIF_ICON_X0 + ICON_W + ICON_HIT_MARGIN),
        game_y_t'(ICON_Y0 - ICON_HIT_MARGIN),
        game_y_t'(ICON_Y0 + ICON_H + ICON_HIT_MARGIN));

    // Keypad icon also covers its text label underneath
    assign hit_kp_icon = in_box(game_x, game_y,
        game_x_t'(KP_ICON_X0 - ICON_HIT_MARGIN),
        game_x_t'(KP_ICON_X0 + ICON_W + ICON_HIT_MARGIN),
        game_y_t'(ICON_Y0 - ICON_HIT_MARGIN),
        game_y_t'(ICON_Y0 + ICON_H + KP_LABEL_EXTRA + ICON_HIT_MARGIN));

    assign hit_brk_icon = in_box(game_x, game_y,
        game_x_t'(BRK_ICON_X0 - ICON_HIT_MARGIN),
        game_x_t'(BRK_ICON_X0 + ICON_W + ICON_HIT_MARGIN),
        game_y_t'(ICON_Y0 - ICON_HIT_MARGIN),
        game_y_t'(ICON_Y0 + ICON_H + ICON_HIT_MARGIN));

    // ----------------------------------------------------------------------
    // Buttons, exact bounds
    // ----------------------------------------------------------------------
    assign hit_home_btn = in_box(game_x, game_y,
        game_x_t'(HOME_BTN_X0), game_x_t'(HOME_BTN_X1), HOME_BTN_Y0, HOME_BTN_Y1);
    assign hit_play = in_box(game_x, game_y,
        game_x_t'(PLAY_X0), game_x_t'(PLAY_X1), PLAY_Y0, PLAY_Y1);
    assign hit_exit = in_box(game_x, game_y,
        game_x_t'(EXIT_X0), game_x_t'(EXIT_X1), EXIT_Y0, EXIT_Y1);

    // ----------------------------------------------------------------------
    // Keypad grid
    // ----------------------------------------------------------------------
    assign key_hit = in_box(game_x, game_y,
        game_x_t'(KEY_X0), game_x_t'(KEY_X0 + KEY_COLS * KEY_W),
        game_y_t'(KEY_Y0), game_y_t'(KEY_Y0 + KEY_ROWS * KEY_H));

    // Count inner grid lines left of / above the point, no divide needed
    always_comb begin
        key_col = 2'd0;
        key_row = 2'd0;
        for (int c = 1; c < KEY_COLS; c++) begin
            if (game_x >= game_x_t'(KEY_X0 + c * KEY_W)) begin
                key_col = key_col + 2'd1;
            end
        end
        for (int r = 1; r < KEY_ROWS; r++) begin
            if (game_y >= game_y_t'(KEY_Y0 + r * KEY_H)) begin
                key_row = key_row + 2'd1;
            end
        end
    end

    // Row * 4 + column
    assign key_value = {key_row, key_col};

endmodule

`default_nettype wire

// ==== rtl/seven_seg_decoder.sv ====
// Hex digit to seven-segment pattern
// Active-low segments, bit 0 drives segment a, bit 6 segment g

`default_nettype none

module seven_seg_decoder (
    input  wire touch_ui_pkg::hex_digit_t value,
    output touch_ui_pkg::seg7_t          seg
);

    // Pattern written as g..a
    always_comb begin
        case (value)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            // Letters, lower case b and d
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/touch_mapper.sv ====
// Touch sample front end
// Turns raw panel coordinates into 320x240 screen coordinates
// Panel axes are swapped and the panel X axis runs opposite to screen Y
// All outputs are registered so the point, tap and press stay coherent

`default_nettype none

module touch_mapper (
    input  wire                     clk_50,
    input  wire                     reset_n,
    input  wire                     touch_valid,
    input  wire                     touch_down,
    input  wire touch_ui_pkg::raw_coord_t touch_x,
    input  wire touch_ui_pkg::raw_coord_t touch_y,
    output touch_ui_pkg::game_x_t   game_x,
    output touch_ui_pkg::game_y_t   game_y,
    output logic                    tap,
    output logic                    press
);

    import touch_ui_pkg::*;

    logic [9:0] x_src;
    game_x_t    x_next;
    logic [7:0] y_src;
    logic [7:0] y_clamped;
    game_y_t    y_next;
    logic       touch_down_d;

    // Screen X comes from panel Y, clipped at the right edge
    assign x_src  = touch_y[9:0];
    assign x_next = (x_src > game_x_t'(GAME_W - 1)) ? game_x_t'(GAME_W - 1) : x_src;

    // Screen Y comes from panel X, clipped then flipped
    assign y_src     = touch_x[7:0];
    assign y_clamped = (y_src > 8'(GAME_H - 1)) ? 8'(GAME_H - 1) : y_src;
    assign y_next    = game_y_t'(GAME_H - 1) - {1'b0, y_clamped};

    always_ff @(posedge clk_50 or negedge reset_n) begin
        if (!reset_n) begin
            touch_down_d <= 1'b0;
            game_x       <= '0;
            game_y       <= '0;
            tap          <= 1'b0;
            press        <= 1'b0;
        end else begin
            touch_down_d <= touch_down;
            game_x       <= x_next;
            game_y       <= y_next;
            // Rising edge of touch_down only counts with a valid sample
            tap          <= touch_valid && touch_down && !touch_down_d;
            press        <= touch_valid && touch_down;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/touch_ui_pkg.sv ====
// Shared types and constants for the touch UI controller
// Holds screen geometry, hitbox bounds, the keypad grid and state encodings
// Compile this package before any other RTL file

`default_nettype none

package touch_ui_pkg;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        HOME     = 2'd0,
        BREAKOUT = 2'd1,
        GIF      = 2'd2,
        KEYPAD   = 2'd3
    } app_state_t;

    // Breakout sub-state, only meaningful while in BREAKOUT
    typedef enum logic [1:0] {
        B_IDLE      = 2'd0,
        B_PLAY      = 2'd1,
        B_GAME_OVER = 2'd2
    } brk_state_t;

    typedef logic [9:0]  game_x_t;
    typedef logic [8:0]  game_y_t;
    typedef logic [11:0] raw_coord_t;
    typedef logic [3:0]  hex_digit_t;
    // Bit 0 is segment a, a low bit lights the segment
    typedef logic [6:0]  seg7_t;

    // ----------------------------------------------------------------------
    // Geometry
    // ----------------------------------------------------------------------
    localparam int GAME_W = 320;
    localparam int GAME_H = 240;

    // Home screen icons
    localparam int ICON_W          = 48;
    localparam int ICON_H          = 48;
    localparam int ICON_MARGIN     = 16;
    localparam int ICON_HIT_MARGIN = 4;
    localparam int GIF_ICON_X0     = ICON_MARGIN;
    localparam int KP_ICON_X0      = (GAME_W - ICON_W) / 2;
    localparam int BRK_ICON_X0     = GAME_W - ICON_W - ICON_MARGIN;
    localparam int ICON_Y0         = ICON_MARGIN;
    // Label gap 8, text height 7, slack 12
    localparam int KP_LABEL_EXTRA  = 8 + 7 + 12;

    // Buttons, X0/Y0 inclusive and X1/Y1 exclusive
    localparam logic [8:0] PLAY_X0     = 9'd90;
    localparam logic [8:0] PLAY_X1     = 9'd230;
    localparam logic [8:0] PLAY_Y0     = 9'd80;
    localparam logic [8:0] PLAY_Y1     = 9'd120;
    localparam logic [8:0] EXIT_X0     = 9'd90;
    localparam logic [8:0] EXIT_X1     = 9'd230;
    localparam logic [8:0] EXIT_Y0     = 9'd140;
    localparam logic [8:0] EXIT_Y1     = 9'd180;
    // Shared by the GIF and keypad apps
    localparam logic [8:0] HOME_BTN_X0 = 9'd120;
    localparam logic [8:0] HOME_BTN_X1 = 9'd200;
    localparam logic [8:0] HOME_BTN_Y0 = 9'd10;
    localparam logic [8:0] HOME_BTN_Y1 = 9'd40;

    // Hex keypad, 4x4 keys, value = row * 4 + column
    localparam int KEY_X0   = 80;
    localparam int KEY_Y0   = 60;
    localparam int KEY_W    = 40;
    localparam int KEY_H    = 40;
    localparam int KEY_COLS = 4;
    localparam int KEY_ROWS = 4;

    // Paddle starts centered
    localparam logic [8:0] PADDLE_RESET_X = 9'd160;

endpackage

`default_nettype wire

// ==== rtl/touch_ui_top.sv ====
// Top level of the touch UI controller
// Touch samples come in from the panel poller, ball_lost from the game core
// Outputs drive the game core, the app screens and the HEX0 display

`default_nettype none

module touch_ui_top (
    input  wire                            clk_50,
    input  wire                            reset_n,
    input  wire                            touch_valid,
    input  wire                            touch_down,
    input  wire touch_ui_pkg::raw_coord_t  touch_x,
    input  wire touch_ui_pkg::raw_coord_t  touch_y,
    input  wire                            ball_lost,
    output touch_ui_pkg::app_state_t       app_state,
    output touch_ui_pkg::brk_state_t       brk_state,
    output logic                           game_run,
    output logic                           new_game,
    output logic [8:0]                     paddle_target_x,
    output touch_ui_pkg::hex_digit_t       selected_hex,
    output touch_ui_pkg::seg7_t            hex0
);

    import touch_ui_pkg::*;

    // Mapped touch, one cycle behind the raw sample
    game_x_t    game_x;
    game_y_t    game_y;
    logic       tap;
    logic       press;

    // Hit flags
    logic       hit_gif_icon;
    logic       hit_kp_icon;
    logic       hit_brk_icon;
    logic       hit_home_btn;
    logic       hit_play;
    logic       hit_exit;
    logic       key_hit;
    hex_digit_t key_value;

    touch_mapper u_touch_mapper (
        .clk_50      (clk_50),
        .reset_n     (reset_n),
        .touch_valid (touch_valid),
        .touch_down  (touch_down),
        .touch_x     (touch_x),
        .touch_y     (touch_y),
        .game_x      (game_x),
        .game_y      (game_y),
        .tap         (tap),
        .press       (press)
    );

    hit_decoder u_hit_decoder (
        .game_x       (game_x),
        .game_y       (game_y),
        .hit_gif_icon (hit_gif_icon),
        .hit_kp_icon  (hit_kp_icon),
        .hit_brk_icon (hit_brk_icon),
        .hit_home_btn (hit_home_btn),
        .hit_play     (hit_play),
        .hit_exit     (hit_exit),
        .key_hit      (key_hit),
        .key_value    (key_value)
    );

    app_controller u_app_controller (
        .clk_50          (clk_50),
        .reset_n         (reset_n),
        .tap             (tap),
        .press           (press),
        .ball_lost       (ball_lost),
        .game_x          (game_x),
        .hit_gif_icon    (hit_gif_icon),
        .hit_kp_icon     (hit_kp_icon),
        .hit_brk_icon    (hit_brk_icon),
        .hit_home_btn    (hit_home_btn),
        .hit_play        (hit_play),
        .hit_exit        (hit_exit),
        .key_hit         (key_hit),
        .key_value       (key_value),
        .app_state       (app_state),
        .brk_state       (brk_state),
        .game_run        (game_run),
        .new_game        (new_game),
        .paddle_target_x (paddle_target_x),
        .selected_hex    (selected_hex)
    );

    // HEX0 shows the latched key
    seven_seg_decoder u_seven_seg_decoder (
        .value (selected_hex),
        .seg   (hex0)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the touch UI testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module tb_touch_ui_top \
    -f touch_ui_top.f

./obj_dir/Vtb_touch_ui_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
else
    exit 1
fi

// ==== testbench/tb_touch_ui_tasks.svh ====
// Shared testbench tasks for the touch UI controller
// Included inside tb_touch_ui_top, uses its signals and the package imports
// Touch stimulus, reference segment table, compare tasks and state waits

`ifndef TB_TOUCH_UI_TASKS_SVH
`define TB_TOUCH_UI_TASKS_SVH

// ----------------------------------------------------------------------
// Touch stimulus
// ----------------------------------------------------------------------

// Tap at a screen point, inverse of the panel rotation
task automatic tap_at(input int x, input int y);
    @(negedge clk_50);
    touch_valid = 1'b1;
    touch_down  = 1'b1;
    touch_x     = raw_coord_t'(GAME_H - 1 - y);
    touch_y     = raw_coord_t'(x);
    repeat (4) @(negedge clk_50);
    touch_down = 1'b0;
    repeat (4) @(negedge clk_50);
    touch_valid = 1'b0;
endtask

// Hold a press with a raw panel Y, then check the paddle target
task automatic press_at(input raw_coord_t ry, input logic [8:0] exp);
    @(negedge clk_50);
    touch_valid = 1'b1;
    touch_down  = 1'b1;
    // Low on screen, clear of every button
    touch_x     = raw_coord_t'(GAME_H - 1 - 200);
    touch_y     = ry;
    repeat (3) @(negedge clk_50);
    check_paddle("paddle_target_x", paddle_target_x, exp);
    touch_down = 1'b0;
    repeat (2) @(negedge clk_50);
    touch_valid = 1'b0;
endtask

// Active-low pattern, built from the lit segments g..a
function automatic seg7_t expected_seg(input hex_digit_t v);
    logic [6:0] lit;
    case (v)
        4'h0: lit = 7'h3F;
        4'h1: lit = 7'h06;
        4'h2: lit = 7'h5B;
        4'h3: lit = 7'h4F;
        4'h4: lit = 7'h66;
        4'h5: lit = 7'h6D;
        4'h6: lit = 7'h7D;
        4'h7: lit = 7'h07;
        4'h8: lit = 7'h7F;
        4'h9: lit = 7'h6F;
        4'hA: lit = 7'h77;
        4'hB: lit = 7'h7C;
        4'hC: lit = 7'h39;
        4'hD: lit = 7'h5E;
        4'hE: lit = 7'h79;
        default: lit = 7'h71;
    endcase
    return ~lit;
endfunction

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic check_app(input string name, input app_state_t got, input app_state_t exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_brk(input string name, input brk_state_t got, input brk_state_t exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_paddle(input string name, input logic [8:0] got, input logic [8:0] exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_hex(input string name, input hex_digit_t got, input hex_digit_t exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_seg(input string name, input seg7_t got, input seg7_t exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

// Pulse counts, e.g. new_game cycles per tap
task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

// ----------------------------------------------------------------------
// State waits, each bounded
// ----------------------------------------------------------------------
task automatic wait_app(input app_state_t exp);
    int cycles;
    cycles = 0;
    while (app_state !== exp && cycles < WAIT_LIMIT) begin
        @(negedge clk_50);
        cycles++;
    end
    if (app_state !== exp) begin
        $display("Timed out waiting for app_state to become 0x%0h", exp);
        abort_run();
    end
endtask

task automatic wait_brk(input brk_state_t exp);
    int cycles;
    cycles = 0;
    while (brk_state !== exp && cycles < WAIT_LIMIT) begin
        @(negedge clk_50);
        cycles++;
    end
    if (brk_state !== exp) begin
        $display("Timed out waiting for brk_state to become 0x%0h", exp);
        abort_run();
    end
endtask

`endif

// ==== testbench/tb_touch_ui_top.sv ====
// Testbench top for the touch UI controller
// Generates clock and reset, drives touch samples on the falling edge
// and runs the directed tests against the DUT one after another

`default_nettype none

module tb_touch_ui_top;

    import touch_ui_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic       clk_50;
    logic       reset_n;
    logic       touch_valid;
    logic       touch_down;
    raw_coord_t touch_x;
    raw_coord_t touch_y;
    logic       ball_lost;
    app_state_t app_state;
    brk_state_t brk_state;
    logic       game_run;
    logic       new_game;
    logic [8:0] paddle_target_x;
    hex_digit_t selected_hex;
    seg7_t      hex0;

    int seed;
    int pulse_count = 0;

    touch_ui_top dut (
        .clk_50          (clk_50),
        .reset_n         (reset_n),
        .touch_valid     (touch_valid),
        .touch_down      (touch_down),
        .touch_x         (touch_x),
        .touch_y         (touch_y),
        .ball_lost       (ball_lost),
        .app_state       (app_state),
        .brk_state       (brk_state),
        .game_run        (game_run),
        .new_game        (new_game),
        .paddle_target_x (paddle_target_x),
        .selected_hex    (selected_hex),
        .hex0            (hex0)
    );

    always #5 clk_50 = ~clk_50;

    // Running count of new_game cycles seen at the falling edge
    always @(negedge clk_50) begin
        if (new_game) begin
            pulse_count = pulse_count + 1;
        end
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    `include "tb_touch_ui_tasks.svh"

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_reset_state();
        check_app("app_state", app_state, HOME);
        check_brk("brk_state", brk_state, B_IDLE);
        check_bit("game_run", game_run, 1'b0);
        check_hex("selected_hex", selected_hex, 4'h0);
        check_seg("hex0", hex0, expected_seg(4'h0));
        // Empty area below the icons
        tap_at(160, 200);
        check_app("app_state", app_state, HOME);
    endtask

    task automatic test_app_navigation();
        tap_at(40, 40);
        wait_app(GIF);
        tap_at(160, 25);
        wait_app(HOME);
        // Label strip under the keypad icon
        tap_at(160, 90);
        wait_app(KEYPAD);
        tap_at(160, 25);
        wait_app(HOME);
    endtask

    task automatic test_breakout_play();
        int pulses_before;
        pulses_before = pulse_count;
        tap_at(280, 40);
        wait_app(BREAKOUT);
        wait_brk(B_PLAY);
        check_count("new_game pulses", pulse_count - pulses_before, 1);
        check_bit("game_run", game_run, 1'b1);
        press_at(12'd0, 9'd0);
        press_at(12'd319, 9'd319);
        press_at(12'd100, 9'd100);
        // Past the right edge
        press_at(12'd900, 9'd319);
    endtask

    task automatic test_breakout_game_over();
        int pulses_before;
        @(negedge clk_50);
        ball_lost = 1'b1;
        wait_brk(B_GAME_OVER);
        ball_lost = 1'b0;
        check_bit("game_run", game_run, 1'b0);
        pulses_before = pulse_count;
        tap_at(160, 100);
        wait_brk(B_PLAY);
        check_count("new_game pulses", pulse_count - pulses_before, 1);
        check_bit("game_run", game_run, 1'b1);
        @(negedge clk_50);
        ball_lost = 1'b1;
        wait_brk(B_GAME_OVER);
        ball_lost = 1'b0;
        tap_at(160, 160);
        wait_app(HOME);
        check_brk("brk_state", brk_state, B_IDLE);
        check_bit("game_run", game_run, 1'b0);
    endtask

    task automatic test_keypad_keys();
        logic [31:0] r;
        int          row;
        int          col;
        int          key;
        tap_at(160, 40);
        wait_app(KEYPAD);
        for (int i = 0; i < 16; i++) begin
            r   = $random(seed);
            col = r % 4;
            row = (r >> 2) % 4;
            key = row * 4 + col;
            // Random point anywhere inside the chosen key
            tap_at(80 + col * 40 + (r >> 8) % 40, 60 + row * 40 + (r >> 16) % 40);
            check_hex("selected_hex", selected_hex, hex_digit_t'(key));
            check_seg("hex0", hex0, expected_seg(hex_digit_t'(key)));
        end
        tap_at(90, 70);
        check_hex("selected_hex", selected_hex, 4'h0);
        tap_at(160, 25);
        wait_app(HOME);
        // Key F position while back at the home screen
        tap_at(230, 210);
        check_app("app_state", app_state, HOME);
        check_hex("selected_hex", selected_hex, 4'h0);
    endtask

    task automatic test_touch_filtering();
        @(negedge clk_50);
        touch_valid = 1'b1;
        touch_down  = 1'b1;
        touch_x     = raw_coord_t'(GAME_H - 1 - 200);
        touch_y     = raw_coord_t'(160);
        repeat (3) @(negedge clk_50);
        // Slide onto the GIF icon without lifting
        touch_x = raw_coord_t'(GAME_H - 1 - 40);
        touch_y = raw_coord_t'(40);
        repeat (4) @(negedge clk_50);
        check_app("app_state", app_state, HOME);
        touch_down = 1'b0;
        repeat (3) @(negedge clk_50);
        // Same icon with an invalid sample
        touch_valid = 1'b0;
        touch_down  = 1'b1;
        repeat (4) @(negedge clk_50);
        check_app("app_state", app_state, HOME);
        touch_down = 1'b0;
        repeat (3) @(negedge clk_50);
    endtask

    initial begin
        clk_50      = 1'b0;
        reset_n     = 1'b0;
        touch_valid = 1'b0;
        touch_down  = 1'b0;
        touch_x     = '0;
        touch_y     = '0;
        ball_lost   = 1'b0;
        seed        = 33;
        repeat (3) @(negedge clk_50);
        reset_n = 1'b1;
        @(negedge clk_50);
        test_reset_state();
        test_app_navigation();
        test_breakout_play();
        test_breakout_game_over();
        test_keypad_keys();
        test_touch_filtering();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== touch_ui_top.f ====
+incdir+testbench
rtl/touch_ui_pkg.sv
rtl/touch_mapper.sv
rtl/hit_decoder.sv
rtl/app_controller.sv
rtl/seven_seg_decoder.sv
rtl/touch_ui_top.sv
testbench/tb_touch_ui_top.sv
